//--- common/delay_pkg.sv
package delay_pkg;

    // APB bus geometry.
    localparam int addr_width  = 32;
    localparam int data_width  = 32;
    localparam int strb_width  = data_width / 8;
    localparam int prot_width  = 3;
    localparam int byte_offset = $clog2(strb_width);   // Byte bits below the word index.

    // Latency scaling.
    localparam int count_width = 32;
    localparam int ratio_shift = 10;                    // Fraction bits, scale 1024.
    localparam logic [count_width-1:0] ratio_num = 32'd10240;   // Ten times slower.

    // When off the delayer returns the memory response unchanged.
    localparam bit delay_enable = 1'b1;

    // Local memory.
    localparam int mem_words      = 64;
    localparam int mem_addr_width = $clog2(mem_words);

    // Address bits [5:2] select the memory wait count.
    localparam int wait_lsb   = 2;
    localparam int wait_width = 4;

    typedef enum logic [1:0] {
        idle,       // Waiting for a setup phase.
        active,     // Downstream access in progress.
        hold,       // Response latched, counting the extra delay.
        respond     // Upstream pready cycle.
    } delay_state_t;

endpackage

//--- common/apb_if.sv
`timescale 1ns/1ps

interface apb_if
    import delay_pkg::*;
();

    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic [prot_width-1:0] pprot;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [strb_width-1:0] pstrb;
    logic                  pready;
    logic [data_width-1:0] prdata;
    logic                  pslverr;

    modport requester (
        output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

//--- apb_delayer/apb_delayer.sv
`timescale 1ns/1ps

module apb_delayer
    import delay_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [addr_width-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic [prot_width-1:0] pprot,
    input  logic                  pwrite,
    input  logic [data_width-1:0] pwdata,
    input  logic [strb_width-1:0] pstrb,
    output logic                  pready,
    output logic [data_width-1:0] prdata,
    output logic                  pslverr,
    apb_if.requester              down
);

    delay_state_t               state;
    logic [count_width-1:0]     wait_cnt;
    logic [count_width-1:0]     delay_cnt;
    logic [2*count_width-1:0]   scaled_full;
    logic [2*count_width-1:0]   scaled_shr;
    logic [count_width-1:0]     scaled;
    logic [count_width-1:0]     delay_calc;
    logic [data_width-1:0]      held_rdata;
    logic                       held_slverr;
    logic                       pready_q;
    logic [data_width-1:0]      prdata_q;
    logic                       pslverr_q;
    logic                       access;
    logic                       down_done;
    logic                       go_direct;
    logic                       go_hold_done;

    // The memory sees the request as issued upstream. During hold it repeats the
    // same transfer, which is harmless since writes and reads are idempotent.
    assign down.paddr   = paddr;
    assign down.psel    = psel;
    assign down.penable = penable;
    assign down.pprot   = pprot;
    assign down.pwrite  = pwrite;
    assign down.pwdata  = pwdata;
    assign down.pstrb   = pstrb;

    assign access    = psel & penable;
    assign down_done = access & down.pready;

    // D = w * ratio - w, floored at zero.
    assign scaled_full = (2*count_width)'(wait_cnt) * (2*count_width)'(ratio_num);
    assign scaled_shr  = scaled_full >> ratio_shift;
    assign scaled      = scaled_shr[count_width-1:0];
    assign delay_calc  = (scaled > wait_cnt) ? scaled - wait_cnt : '0;

    assign go_direct    = (state == active) && down_done && (delay_calc == '0);
    assign go_hold_done = (state == hold) && (delay_cnt == count_width'(1));

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= idle;
            wait_cnt  <= '0;
            delay_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    wait_cnt <= '0;
                    if (delay_enable && psel && !penable) begin
                        state <= active;    // Setup phase seen.
                    end
                end
                active: begin
                    if (down_done) begin
                        delay_cnt <= delay_calc;
                        state     <= go_direct ? respond : hold;
                    end else if (access) begin
                        wait_cnt <= wait_cnt + count_width'(1);
                    end
                end
                hold: begin
                    delay_cnt <= delay_cnt - count_width'(1);
                    if (go_hold_done) begin
                        state <= respond;
                    end
                end
                respond: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if ((state == active) && down_done) begin
            held_rdata  <= down.prdata;
            held_slverr <= down.pslverr;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            pready_q  <= 1'b0;
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q <= go_direct || go_hold_done;
            if (go_direct) begin
                prdata_q  <= down.prdata;     // Zero extra delay.
                pslverr_q <= down.pslverr;
            end else if (go_hold_done) begin
                prdata_q  <= held_rdata;
                pslverr_q <= held_slverr;
            end else begin
                prdata_q  <= '0;
                pslverr_q <= 1'b0;
            end
        end
    end

    assign pready  = delay_enable ? pready_q  : down.pready;
    assign prdata  = delay_enable ? prdata_q  : down.prdata;
    assign pslverr = delay_enable ? pslverr_q : down.pslverr;

    a_pready_in_access: assert property (@(posedge clock) disable iff (!reset)
        pready |-> psel && penable)
        else $error("apb_delayer: pready high outside an access phase");

    a_hold_stable: assert property (@(posedge clock) disable iff (!reset)
        state == hold |-> psel && penable && $stable(paddr) && $stable(pwrite)
                          && $stable(pwdata) && $stable(pstrb))
        else $error("apb_delayer: request changed while response is held");

endmodule

//--- rtl/apb_sram.sv
`timescale 1ns/1ps

module apb_sram
    import delay_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    apb_if.completer bus
);

    logic [data_width-1:0]             mem [mem_words];
    logic [addr_width-byte_offset-1:0] word_addr;
    logic [mem_addr_width-1:0]         mem_index;
    logic [wait_width-1:0]             addr_wait;
    logic [wait_width-1:0]             wait_cnt;
    logic [wait_width-1:0]             cur_wait;
    logic                              in_access;
    logic                              access;
    logic                              first;
    logic                              ready;
    logic                              in_range;
    logic                              wr_en;
    logic                              rd_en;

    assign word_addr = bus.paddr[addr_width-1:byte_offset];
    assign mem_index = word_addr[mem_addr_width-1:0];
    assign addr_wait = bus.paddr[wait_lsb +: wait_width];
    assign in_range  = (word_addr < (addr_width - byte_offset)'(mem_words));

    assign access   = bus.psel & bus.penable;
    assign first    = access & ~in_access;
    assign cur_wait = first ? addr_wait : wait_cnt;    // Count loads on first access cycle.
    assign ready    = access & (cur_wait == '0);

    always_ff @(posedge clock) begin
        if (!reset) begin
            in_access <= 1'b0;
            wait_cnt  <= '0;
        end else if (access && !ready) begin
            in_access <= 1'b1;
            wait_cnt  <= cur_wait - wait_width'(1);
        end else begin
            in_access <= 1'b0;                          // Ready or bus idle.
        end
    end

    assign wr_en = ready & bus.pwrite & in_range;
    assign rd_en = ready & ~bus.pwrite & in_range;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int i = 0; i < strb_width; i++) begin
                if (bus.pstrb[i]) begin
                    mem[mem_index][8*i +: 8] <= bus.pwdata[8*i +: 8];
                end
            end
        end
    end

    assign bus.pready  = ready;
    assign bus.prdata  = rd_en ? mem[mem_index] : '0;
    assign bus.pslverr = ready & ~in_range;           // Out of range word.

    a_penable_needs_psel: assert property (@(posedge clock) disable iff (!reset)
        $rose(bus.penable) |-> bus.psel)
        else $error("apb_sram: penable rose without psel");

endmodule

//--- rtl/delay_top.sv
`timescale 1ns/1ps

module delay_top
    import delay_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic [addr_width-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic [prot_width-1:0] pprot,
    input  logic                  pwrite,
    input  logic [data_width-1:0] pwdata,
    input  logic [strb_width-1:0] pstrb,
    output logic                  pready,
    output logic [data_width-1:0] prdata,
    output logic                  pslverr
);

    // Link between the delayer and the memory.
    apb_if u_apb_if ();

    apb_delayer u_apb_delayer (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr),
        .down    (u_apb_if.requester)
    );

    apb_sram u_apb_sram (
        .clock (clock),
        .reset (reset),
        .bus   (u_apb_if.completer)
    );

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period  = 5;    // 10 ns clock.
    localparam int reset_cycles = 2;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b1;                // Released just after the edge.
    end

endmodule

//--- bench/tb_delay_top.sv
`timescale 1ns/1ps

module tb_delay_top
    import delay_pkg::*;
();

    localparam int drive_delay = 1;             // Inputs change 1 ns after the rising edge.
    localparam int case_budget = 10 * 15 + 20;  // Cycles allowed per case.
    localparam int max_cycles  = case_budget;

    logic                  clock;
    logic                  reset;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic [prot_width-1:0] pprot;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [strb_width-1:0] pstrb;
    logic                  pready;
    logic [data_width-1:0] prdata;
    logic                  pslverr;

    logic [data_width-1:0] shadow [mem_words];  // Expected memory contents.
    logic                  case_write [$];
    logic [addr_width-1:0] case_addr [$];
    logic [data_width-1:0] case_wdata [$];
    logic [strb_width-1:0] case_strb [$];
    logic [data_width-1:0] case_rdata [$];
    int                    case_count;
    bit                    cases_ready;
    int                    error_count;
    int                    check_count;
    integer                seed = 32'hdd92_6fc3;

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    delay_top u_delay_top (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    function automatic int wait_of(input logic [addr_width-1:0] addr);
        return int'(addr[wait_lsb +: wait_width]);
    endfunction

    function automatic bit in_range(input logic [addr_width-1:0] addr);
        return addr < addr_width'(mem_words * strb_width);
    endfunction

    // Access phase length seen upstream, pready cycle included.
    function automatic int access_length(input int w);
        logic [63:0] scaled;
        int          extra;
        scaled = (64'(w) * 64'(ratio_num)) >> ratio_shift;
        extra  = (int'(scaled) > w) ? int'(scaled) - w : 0;
        if (delay_enable) begin
            return w + 1 + extra + 1;
        end else begin
            return w + 1;
        end
    endfunction

    task automatic check_value(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_write;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_strb;
        logic [31:0] f_rdata;
        fd = $fopen("bench/delay_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the cases file bench/delay_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", f_write, f_addr, f_wdata, f_strb, f_rdata);
                if (n == 5) begin
                    case_write.push_back(f_write[0]);
                    case_addr.push_back(f_addr);
                    case_wdata.push_back(f_wdata);
                    case_strb.push_back(f_strb[strb_width-1:0]);
                    case_rdata.push_back(f_rdata);
                end
            end
        end
        $fclose(fd);
        case_count = case_write.size();
    endtask

    // Setup and access phase; starts 1 ns after a rising edge and ends the same way.
    task automatic run_transfer(
        input  logic                  write,
        input  logic [addr_width-1:0] addr,
        input  logic [data_width-1:0] wdata,
        input  logic [strb_width-1:0] strb,
        output logic [data_width-1:0] rdata,
        output logic                  slverr,
        output int                    cycles
    );
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        check_value("pready", '0, data_width'(pready));     // Low in setup.
        @(posedge clock);
        #drive_delay;
        penable = 1'b1;
        cycles  = 0;
        rdata   = '0;
        slverr  = 1'b0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!pready && cycles < max_cycles);
        assert (pready === 1'b1)
        else begin
            error_count++;
            $display("Transfer to address %h saw no pready in %0d cycles", addr, max_cycles);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clock);
        #drive_delay;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        int                    w;
        int                    gap;
        int                    widx;
        int                    cycles;
        logic [data_width-1:0] rdata;
        logic [data_width-1:0] model;
        logic                  slverr;
        logic                  err_exp;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pprot       = '0;
        pwrite      = 1'b0;
        pwdata      = '0;
        pstrb       = '0;
        error_count = 0;
        check_count = 0;
        case_count  = 0;
        cases_ready = 1'b0;
        load_cases();
        cases_ready = 1'b1;

        wait (reset === 1'b1);
        @(negedge clock);
        check_value("pready", '0, data_width'(pready));
        check_value("prdata", '0, prdata);
        check_value("pslverr", '0, data_width'(pslverr));
        @(posedge clock);
        #drive_delay;

        for (int i = 0; i < case_count; i++) begin
            w       = wait_of(case_addr[i]);
            err_exp = !in_range(case_addr[i]);
            widx    = int'(case_addr[i][byte_offset +: mem_addr_width]);
            run_transfer(case_write[i], case_addr[i], case_wdata[i], case_strb[i],
                         rdata, slverr, cycles);
            check_value("access cycles", 32'(access_length(w)), 32'(cycles));
            check_value("pslverr", data_width'(err_exp), data_width'(slverr));
            if (case_write[i]) begin
                if (!err_exp) begin
                    for (int b = 0; b < strb_width; b++) begin
                        if (case_strb[i][b]) begin
                            shadow[widx][8*b +: 8] = case_wdata[i][8*b +: 8];
                        end
                    end
                end
            end else begin
                model = err_exp ? '0 : shadow[widx];
                assert (model === case_rdata[i])
                else begin
                    error_count++;
                    $display("Cases file expects %h at address %h but the writes give %h",
                             case_rdata[i], case_addr[i], model);
                end
                check_value("prdata", model, rdata);
            end
            gap = (w == 15) ? 0 : ($random(seed) & 3);      // Back to back after long waits.
            repeat (gap) begin
                @(posedge clock);
                #drive_delay;
            end
        end

        $display("Cases: %0d, checks: %0d, errors: %0d", case_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (cases_ready);
        repeat ((case_count + 1) * case_budget) @(posedge clock);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 (case_count + 1) * case_budget);
        $display("Cases: %0d, checks: %0d, errors: %0d", case_count, check_count, error_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- bench/delay_cases.txt
# Columns: write flag, byte address, write data, strobe, expected read data (hex).
# Wait count is address bits [5:2]; the read data column is ignored for writes.
1 00000000 11223344 f 00000000
0 00000000 00000000 0 11223344
1 00000004 a5a5a5a5 f 00000000
0 00000004 00000000 0 a5a5a5a5
1 00000004 0000bb00 2 00000000
0 00000004 00000000 0 a5a5bba5
1 0000003c deadbeef f 00000000
0 0000003c 00000000 0 deadbeef
1 00000040 cafef00d f 00000000
1 00000040 12345678 c 00000000
0 00000040 00000000 0 1234f00d
1 00000104 ffffffff f 00000000
0 00000104 00000000 0 00000000
0 00000004 00000000 0 a5a5bba5
1 000000fc 76543210 f 00000000
1 000000fc 000000aa 1 00000000
0 000000fc 00000000 0 765432aa
0 00000100 00000000 0 00000000
1 00000020 01020304 f 00000000
0 00000020 00000000 0 01020304
1 00000020 f0000000 8 00000000
0 00000020 00000000 0 f0020304
1 00000044 0f0f0f0f f 00000000
1 00000044 0000a000 2 00000000
0 00000044 00000000 0 0f0fa00f
0 0000003c 00000000 0 deadbeef
0 00000000 00000000 0 11223344
0 000000fc 00000000 0 765432aa

//--- flist.f
common/delay_pkg.sv
common/apb_if.sv
apb_delayer/apb_delayer.sv
rtl/apb_sram.sv
rtl/delay_top.sv
bench/clock_gen.sv
bench/tb_delay_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_delay_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FLIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(BUILD_DIR)
